// File: Makefile
# Verilator flow for the banked atomic scratchpad

VERILATOR ?= verilator
VFLAGS    := --timing --assert
TB_TOP    := tb_amo_mem
RTL_TOP   := amo_mem_top
FILELIST  := amo_mem_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TB_TOP) -f $(FILELIST)

# Pass only when the testbench prints the pass line
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: amo_mem_pkg.sv
/*
  Shared widths, typedefs and helpers for the banked atomic scratchpad
  The data path is fixed at 32 bits with four byte enables
  Opcodes C to F are carried through the design but rejected by the banks
*/
`default_nettype none

package amo_mem_pkg;

  // Bus widths
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [BeWidth-1:0]   be_t;

  // Atomic opcode as carried on the sideband
  typedef enum logic [3:0] {
    NONE = 4'h0,
    SWAP = 4'h1,
    ADD  = 4'h2,
    AND  = 4'h3,
    OR   = 4'h4,
    XOR  = 4'h5,
    MAX  = 4'h6,
    MAXU = 4'h7,
    MIN  = 4'h8,
    MINU = 4'h9,
    LR   = 4'hA,
    SC   = 4'hB
  } amo_op_e;

  // Read-modify-write group, SWAP up to MINU
  function automatic logic is_rmw(input logic [3:0] op);
    return (op >= 4'h1) && (op <= 4'h9);
  endfunction

  function automatic logic is_legal_op(input logic [3:0] op);
    return op <= 4'hB;
  endfunction

  // Index width for a count, at least one bit
  function automatic int unsigned idx_width(input int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

`default_nettype wire

// File: amo_mem_top.f
amo_mem_pkg.sv
bank_sram.sv
bank_amo_adapter.sv
wb_bank_router.sv
bank_resp_collect.sv
amo_mem_top.sv
tb_clock_gen.sv
tb_amo_mem.sv

// File: amo_mem_top.sv
/*
  Banked scratchpad with atomics behind a Wishbone classic slave
  NUM_BANKS must be a power of two and at least two
  Bank and word fields must fit inside the 16-bit byte address
*/
`timescale 1ns/100ps
`default_nettype none

module amo_mem_top #(
  parameter int unsigned NUM_BANKS      = 4,
  parameter int unsigned WORDS_PER_BANK = 64,
  parameter int unsigned HART_ID_W      = 4
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 wb_cyc_i,
  input  wire logic                 wb_stb_i,
  input  wire logic                 wb_we_i,
  input  amo_mem_pkg::addr_t        wb_adr_i,
  input  amo_mem_pkg::be_t          wb_sel_i,
  input  amo_mem_pkg::data_t        wb_dat_i,
  input  wire logic [3:0]           amo_op_i,
  input  wire logic [HART_ID_W-1:0] hart_id_i,
  output amo_mem_pkg::data_t        wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      wb_err_o
);

  localparam int unsigned WORD_W = amo_mem_pkg::idx_width(WORDS_PER_BANK);

  // Router to banks, request payload shared by all banks
  logic [NUM_BANKS-1:0] bank_req;
  logic [WORD_W-1:0] word_addr;
  logic write;
  amo_mem_pkg::data_t wdata;
  amo_mem_pkg::be_t be;
  amo_mem_pkg::amo_op_e op;
  logic [HART_ID_W-1:0] hart_id;

  // Banks to collector
  logic [NUM_BANKS-1:0] resp_valid;
  logic [NUM_BANKS-1:0] resp_err;
  amo_mem_pkg::data_t [NUM_BANKS-1:0] rdata;
  logic done;

  wb_bank_router #(
    .NUM_BANKS      (NUM_BANKS),
    .WORDS_PER_BANK (WORDS_PER_BANK),
    .HART_ID_W      (HART_ID_W)
  ) u_router (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .amo_op_i    (amo_op_i),
    .hart_id_i   (hart_id_i),
    .done_i      (done),
    .bank_req_o  (bank_req),
    .word_addr_o (word_addr),
    .write_o     (write),
    .wdata_o     (wdata),
    .be_o        (be),
    .op_o        (op),
    .hart_id_o   (hart_id)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    bank_amo_adapter #(
      .WORDS_PER_BANK (WORDS_PER_BANK),
      .HART_ID_W      (HART_ID_W)
    ) u_adapter (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (bank_req[b]),
      .word_addr_i  (word_addr),
      .write_i      (write),
      .wdata_i      (wdata),
      .be_i         (be),
      .op_i         (op),
      .hart_id_i    (hart_id),
      .resp_valid_o (resp_valid[b]),
      .resp_err_o   (resp_err[b]),
      .rdata_o      (rdata[b])
    );
  end

  bank_resp_collect #(
    .NUM_BANKS (NUM_BANKS)
  ) u_collect (
    .resp_valid_i (resp_valid),
    .resp_err_i   (resp_err),
    .rdata_i      (rdata),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .wb_dat_o     (wb_dat_o),
    .done_o       (done)
  );

endmodule

`default_nettype wire

// File: bank_amo_adapter.sv
/*
  Bank front end with exclusive access to one SRAM
  Accepts at most one request at a time, the router guarantees this
  RMW atomics take two SRAM cycles and answer one cycle later than others
  One LR/SC reservation per bank, SC always writes the full word
*/
`timescale 1ns/100ps
`default_nettype none

module bank_amo_adapter #(
  parameter int unsigned  WORDS_PER_BANK = 64,
  parameter int unsigned  HART_ID_W      = 4,
  localparam int unsigned WORD_W         = amo_mem_pkg::idx_width(WORDS_PER_BANK)
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 req_i,
  input  wire logic [WORD_W-1:0]    word_addr_i,
  input  wire logic                 write_i,
  input  amo_mem_pkg::data_t        wdata_i,
  input  amo_mem_pkg::be_t          be_i,
  input  amo_mem_pkg::amo_op_e      op_i,
  input  wire logic [HART_ID_W-1:0] hart_id_i,
  output logic                      resp_valid_o,
  output logic                      resp_err_o,
  output amo_mem_pkg::data_t        rdata_o
);

  typedef enum logic {IDLE, WRITE_BACK} state_e;
  state_e state_q, state_d;

  logic legal, rmw_req;
  logic sram_req, sram_we;
  logic [WORD_W-1:0] sram_addr;
  amo_mem_pkg::data_t sram_wdata, sram_rdata, alu_res;
  amo_mem_pkg::be_t sram_be;

  // Response flags
  logic pend_q, err_q, sc_q, sc_ok_q, rmw_done_q;
  logic sc_ok_d;

  // Latched RMW operation
  amo_mem_pkg::amo_op_e op_q;
  logic [WORD_W-1:0] addr_q;
  amo_mem_pkg::data_t operand_q;

  // Reservation set
  logic res_valid_q, res_valid_d;
  logic [WORD_W-1:0] res_addr_q, res_addr_d;
  logic [HART_ID_W-1:0] res_hart_q, res_hart_d;

  assign legal   = amo_mem_pkg::is_legal_op(op_i);
  assign rmw_req = req_i && amo_mem_pkg::is_rmw(op_i);

  // ----------------------------------------
  // LR/SC reservation
  // ----------------------------------------
  always_comb begin
    res_valid_d = res_valid_q;
    res_addr_d  = res_addr_q;
    res_hart_d  = res_hart_q;
    sc_ok_d     = 1'b0;
    if (req_i && legal) begin
      // A hart never steals a reservation held by another one
      if (op_i == amo_mem_pkg::LR && (!res_valid_q || res_hart_q == hart_id_i)) begin
        res_valid_d = 1'b1;
        res_addr_d  = word_addr_i;
        res_hart_d  = hart_id_i;
      end
      // Foreign store or RMW to the reserved word
      // (a foreign SC cannot succeed while this hart holds the set)
      if (res_valid_q && res_hart_q != hart_id_i && res_addr_q == word_addr_i &&
          ((op_i == amo_mem_pkg::NONE && write_i) || amo_mem_pkg::is_rmw(op_i))) begin
        res_valid_d = 1'b0;
      end
      // Any SC by the holder ends the reservation
      if (res_valid_q && op_i == amo_mem_pkg::SC && res_hart_q == hart_id_i) begin
        res_valid_d = 1'b0;
        sc_ok_d     = (res_addr_q == word_addr_i);
      end
    end
  end

  // ----------------------------------------
  // SRAM control
  // ----------------------------------------
  always_comb begin
    state_d    = state_q;
    sram_req   = 1'b0;
    sram_we    = 1'b0;
    sram_addr  = word_addr_i;
    sram_wdata = wdata_i;
    sram_be    = be_i;
    unique case (state_q)
      IDLE: begin
        // Illegal opcodes never touch the array
        if (req_i && legal) begin
          sram_req = 1'b1;
          if (op_i == amo_mem_pkg::NONE) begin
            sram_we = write_i;
          end else if (op_i == amo_mem_pkg::SC) begin
            sram_we = sc_ok_d;
            sram_be = '1;
          end
          if (rmw_req) begin
            state_d = WRITE_BACK;
          end
        end
      end
      WRITE_BACK: begin
        // Full-word commit of the ALU result
        sram_req   = 1'b1;
        sram_we    = 1'b1;
        sram_addr  = addr_q;
        sram_wdata = alu_res;
        sram_be    = '1;
        state_d    = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  bank_sram #(
    .WORDS_PER_BANK (WORDS_PER_BANK)
  ) u_sram (
    .clk_i   (clk_i),
    .req_i   (sram_req),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .be_i    (sram_be),
    .rdata_o (sram_rdata)
  );

  // AMO ALU, old word against latched operand
  always_comb begin
    unique case (op_q)
      amo_mem_pkg::ADD:  alu_res = sram_rdata + operand_q;
      amo_mem_pkg::AND:  alu_res = sram_rdata & operand_q;
      amo_mem_pkg::OR:   alu_res = sram_rdata | operand_q;
      amo_mem_pkg::XOR:  alu_res = sram_rdata ^ operand_q;
      amo_mem_pkg::MAX:  alu_res = ($signed(sram_rdata) > $signed(operand_q)) ?
                                   sram_rdata : operand_q;
      amo_mem_pkg::MAXU: alu_res = (sram_rdata > operand_q) ? sram_rdata : operand_q;
      amo_mem_pkg::MIN:  alu_res = ($signed(sram_rdata) < $signed(operand_q)) ?
                                   sram_rdata : operand_q;
      amo_mem_pkg::MINU: alu_res = (sram_rdata < operand_q) ? sram_rdata : operand_q;
      // SWAP and anything else store the operand
      default:           alu_res = operand_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      pend_q      <= 1'b0;
      err_q       <= 1'b0;
      sc_q        <= 1'b0;
      sc_ok_q     <= 1'b0;
      rmw_done_q  <= 1'b0;
      res_valid_q <= 1'b0;
      res_addr_q  <= '0;
      res_hart_q  <= '0;
    end else begin
      state_q     <= state_d;
      pend_q      <= req_i && !rmw_req;
      err_q       <= req_i && !legal;
      sc_q        <= req_i && op_i == amo_mem_pkg::SC;
      sc_ok_q     <= sc_ok_d;
      rmw_done_q  <= (state_q == WRITE_BACK);
      res_valid_q <= res_valid_d;
      res_addr_q  <= res_addr_d;
      res_hart_q  <= res_hart_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rmw_req) begin
      op_q      <= op_i;
      addr_q    <= word_addr_i;
      operand_q <= wdata_i;
    end
  end

  // SC status replaces read data
  // The write-back cycle reads the old word again, so an RMW returns it here
  assign resp_valid_o = pend_q || rmw_done_q;
  assign resp_err_o   = err_q;
  assign rdata_o      = err_q ? '0 :
                        sc_q  ? amo_mem_pkg::data_t'(!sc_ok_q) : sram_rdata;

  a_no_req_in_wb : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> state_q == IDLE);
  // Single-cycle response pulse
  a_resp_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !rmw_req) |=> resp_valid_o ##1 !resp_valid_o);
  a_resp_rmw : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rmw_req |=> !resp_valid_o ##1 resp_valid_o);

endmodule

`default_nettype wire

// File: bank_resp_collect.sv
/*
  Merges the bank responses into the Wishbone response
  Purely combinational, at most one bank answers in any cycle
*/
`timescale 1ns/100ps
`default_nettype none

module bank_resp_collect #(
  parameter int unsigned NUM_BANKS = 4
) (
  input  wire logic [NUM_BANKS-1:0]             resp_valid_i,
  input  wire logic [NUM_BANKS-1:0]             resp_err_i,
  input  amo_mem_pkg::data_t [NUM_BANKS-1:0]    rdata_i,
  output logic                                  wb_ack_o,
  output logic                                  wb_err_o,
  output amo_mem_pkg::data_t                    wb_dat_o,
  output logic                                  done_o
);

  amo_mem_pkg::data_t dat;

  // AND-OR mux on the one-hot valid vector
  always_comb begin
    dat = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (resp_valid_i[b]) begin
        dat = dat | rdata_i[b];
      end
    end
  end

  assign wb_dat_o = dat;

  // Error takes the place of ack, never both
  assign wb_ack_o = |(resp_valid_i & ~resp_err_i);
  assign wb_err_o = |(resp_valid_i & resp_err_i);

  // Either kind of response frees the router
  assign done_o = |resp_valid_i;

  // Overlapping responses would mean the router issued twice
  always_comb begin
    a_onehot : assert ($onehot0(resp_valid_i))
      else $error("bank responses overlap, valid=%h", resp_valid_i);
  end

endmodule

`default_nettype wire

// File: bank_sram.sv
/*
  Single-port word SRAM model with byte enables
  Read data is registered, one cycle after req_i
  A write also returns the word as it was before the write
*/
`timescale 1ns/100ps
`default_nettype none

module bank_sram #(
  parameter int unsigned  WORDS_PER_BANK = 64,
  localparam int unsigned WORD_W         = amo_mem_pkg::idx_width(WORDS_PER_BANK)
) (
  input  wire logic                clk_i,
  input  wire logic                req_i,
  input  wire logic                we_i,
  input  wire logic [WORD_W-1:0]   addr_i,
  input  amo_mem_pkg::data_t       wdata_i,
  input  amo_mem_pkg::be_t         be_i,
  output amo_mem_pkg::data_t       rdata_o
);

  // Storage array, contents undefined after power up
  amo_mem_pkg::data_t mem_q [WORDS_PER_BANK];
  amo_mem_pkg::data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      // Old word goes out on both reads and writes
      rdata_q <= mem_q[addr_i];
      if (we_i) begin
        for (int b = 0; b < amo_mem_pkg::BeWidth; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: tb_amo_mem.sv
/*
  Testbench for the banked atomic scratchpad, random stimulus from a fixed seed
  Inputs change on falling edges, responses are sampled on falling edges
  The memory is filled first, so every model word is known before it is read
*/
`timescale 1ns/100ps
`default_nettype none

module tb_amo_mem;

  localparam int unsigned NUM_BANKS      = 4;
  localparam int unsigned WORDS_PER_BANK = 64;
  localparam int unsigned HART_ID_W      = 4;
  localparam int unsigned TOTAL_WORDS    = NUM_BANKS * WORDS_PER_BANK;
  localparam int unsigned N_LS           = 64;
  localparam int unsigned N_RMW          = 200;
  // Fill, loads and stores, RMW, LR/SC success, LR/SC loss, illegal opcodes
  localparam int unsigned N_TXN       = TOTAL_WORDS + 2 * N_LS + 2 * N_RMW + 5 + 13 + 8;
  localparam int unsigned CYCLE_LIMIT = N_TXN * 6 + 50;
  localparam int unsigned RESP_LIMIT  = 5;
  localparam int unsigned SEED        = 32'hfeed_2d44;
  localparam logic [HART_ID_W-1:0] HART_A = HART_ID_W'(1);
  localparam logic [HART_ID_W-1:0] HART_B = HART_ID_W'(2);

  wire logic clk_i;
  wire logic rst_ni;
  logic wb_cyc_i, wb_stb_i, wb_we_i;
  amo_mem_pkg::addr_t wb_adr_i;
  amo_mem_pkg::be_t wb_sel_i;
  amo_mem_pkg::data_t wb_dat_i, wb_dat_o;
  logic [3:0] amo_op_i;
  logic [HART_ID_W-1:0] hart_id_i;
  logic wb_ack_o, wb_err_o;

  // Reference memory and one reservation per bank
  amo_mem_pkg::data_t model_mem [TOTAL_WORDS];
  logic res_valid [NUM_BANKS];
  int unsigned res_word [NUM_BANKS];
  logic [HART_ID_W-1:0] res_hart [NUM_BANKS];

  int unsigned err_cnt, test_err0, test_cnt, txn_cnt, cycle_cnt;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) u_clk (.clk_o(clk_i), .rst_no(rst_ni));

  amo_mem_top #(
    .NUM_BANKS      (NUM_BANKS),
    .WORDS_PER_BANK (WORDS_PER_BANK),
    .HART_ID_W      (HART_ID_W)
  ) UUT (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
    .wb_adr_i (wb_adr_i), .wb_sel_i (wb_sel_i), .wb_dat_i (wb_dat_i),
    .amo_op_i (amo_op_i), .hart_id_i (hart_id_i),
    .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o), .wb_err_o (wb_err_o)
  );

  // Global watchdog
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing", cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic amo_mem_pkg::data_t alu_model(input logic [3:0] op,
      input amo_mem_pkg::data_t mem_v, input amo_mem_pkg::data_t opd);
    case (op)
      4'h2: return mem_v + opd;
      4'h3: return mem_v & opd;
      4'h4: return mem_v | opd;
      4'h5: return mem_v ^ opd;
      4'h6: return ($signed(mem_v) >= $signed(opd)) ? mem_v : opd;
      4'h7: return (mem_v >= opd) ? mem_v : opd;
      4'h8: return ($signed(mem_v) <= $signed(opd)) ? mem_v : opd;
      4'h9: return (mem_v <= opd) ? mem_v : opd;
      default: return opd;
    endcase
  endfunction

  task automatic model_access(input logic we, input int unsigned idx, input amo_mem_pkg::be_t sel,
      input amo_mem_pkg::data_t dat, input logic [3:0] op, input logic [HART_ID_W-1:0] hart,
      output amo_mem_pkg::data_t exp_data, output logic exp_err, output logic check_data);
    int unsigned bank;
    int unsigned word;
    logic rmw;
    logic sc_ok;
    bank = idx % NUM_BANKS;
    word = idx / NUM_BANKS;
    rmw = (op >= 4'h1) && (op <= 4'h9);
    exp_err = (op > 4'hB);
    exp_data = model_mem[idx];
    check_data = !exp_err && !(op == 4'h0 && we);
    sc_ok = 1'b0;
    if (!exp_err) begin
      // Foreign store or RMW on the reserved word
      if (res_valid[bank] && res_hart[bank] != hart && res_word[bank] == word &&
          ((op == 4'h0 && we) || rmw)) begin
        res_valid[bank] = 1'b0;
      end
      if (op == 4'hA && (!res_valid[bank] || res_hart[bank] == hart)) begin
        res_valid[bank] = 1'b1;
        res_word[bank]  = word;
        res_hart[bank]  = hart;
      end
      if (op == 4'hB && res_valid[bank] && res_hart[bank] == hart) begin
        sc_ok = (res_word[bank] == word);
        res_valid[bank] = 1'b0;
      end
      if (op == 4'h0 && we) begin
        for (int b = 0; b < 4; b++) begin
          if (sel[b]) model_mem[idx][8*b +: 8] = dat[8*b +: 8];
        end
      end else if (rmw) begin
        model_mem[idx] = alu_model(op, exp_data, dat);
      end else if (op == 4'hB) begin
        if (sc_ok) model_mem[idx] = dat;
        exp_data = {31'b0, !sc_ok};
      end
    end
  endtask

  // ----------------------------------------
  // Bus transaction with response checks
  // ----------------------------------------
  task automatic run_txn(input logic we, input int unsigned idx, input amo_mem_pkg::be_t sel,
      input amo_mem_pkg::data_t dat, input logic [3:0] op, input logic [HART_ID_W-1:0] hart,
      output amo_mem_pkg::data_t rd);
    amo_mem_pkg::data_t exp_data;
    logic exp_err, check_data, seen;
    int unsigned wait_cyc, resp_cnt, exp_lat;
    model_access(we, idx, sel, dat, op, hart, exp_data, exp_err, check_data);
    exp_lat = ((op >= 4'h1) && (op <= 4'h9)) ? 2 : 1;
    txn_cnt++;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i = we;
    wb_adr_i = amo_mem_pkg::addr_t'(idx << 2);
    wb_sel_i = sel;
    wb_dat_i = dat;
    amo_op_i = op;
    hart_id_i = hart;
    seen = 1'b0;
    wait_cyc = 0;
    resp_cnt = 0;
    rd = '0;
    while (!seen && wait_cyc < RESP_LIMIT) begin
      @(negedge clk_i);
      wait_cyc++;
      seen = wb_ack_o || wb_err_o;
    end
    if (!seen) begin
      $display("no response to op %h on word %0d within %0d cycles", op, idx, RESP_LIMIT);
      err_cnt++;
    end else begin
      resp_cnt = 1;
      rd = wb_dat_o;
      if (wait_cyc != exp_lat) begin
        $display("op %h on word %0d answered after %0d cycles instead of %0d",
                 op, idx, wait_cyc, exp_lat);
        err_cnt++;
      end
      if (wb_ack_o !== !exp_err) begin
        $display("error wb_ack_o exp %h got %h (op %h word %0d)", !exp_err, wb_ack_o, op, idx);
        err_cnt++;
      end
      if (wb_err_o !== exp_err) begin
        $display("error wb_err_o exp %h got %h (op %h word %0d)", exp_err, wb_err_o, op, idx);
        err_cnt++;
      end
      if (check_data && wb_dat_o !== exp_data) begin
        $display("error wb_dat_o exp %h got %h (op %h word %0d)", exp_data, wb_dat_o, op, idx);
        err_cnt++;
      end
      // Strobe stays up through the cycle after the response
      @(negedge clk_i);
      if (wb_ack_o || wb_err_o) resp_cnt++;
    end
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    @(negedge clk_i);
    if (wb_ack_o || wb_err_o) resp_cnt++;
    if (resp_cnt > 1) begin
      $display("op %h on word %0d got %0d responses instead of one", op, idx, resp_cnt);
      err_cnt++;
    end
  endtask

  task automatic check_sc(input amo_mem_pkg::data_t got, input logic exp_fail);
    if (got !== {31'b0, exp_fail}) begin
      $display("error wb_dat_o exp %h got %h (SC status)", {31'b0, exp_fail}, got);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  function automatic logic [HART_ID_W-1:0] rand_hart();
    logic [31:0] r;
    r = $urandom;
    return r[HART_ID_W-1:0];
  endfunction

  function automatic amo_mem_pkg::data_t fill_word(input int unsigned idx);
    return {~idx[15:0], idx[15:0]} ^ 32'h3c5a_96e1;
  endfunction

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    amo_mem_pkg::data_t rd, opd;
    int unsigned w;
    int unsigned ls_idx [N_LS];
    logic [3:0] op;
    void'($urandom(SEED));
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
    wb_adr_i = '0;
    wb_sel_i = '0;
    wb_dat_i = '0;
    amo_op_i = 4'h0;
    hart_id_i = '0;
    {err_cnt, test_err0, test_cnt, txn_cnt, cycle_cnt} = '0;
    for (int b = 0; b < NUM_BANKS; b++) res_valid[b] = 1'b0;
    @(posedge rst_ni);
    @(negedge clk_i);

    for (int unsigned i = 0; i < TOTAL_WORDS; i++) begin
      run_txn(1'b1, i, 4'hf, fill_word(i), 4'h0, '0, rd);
    end
    end_test("fill");

    // Byte-enabled stores, then loads of the same words
    for (int unsigned i = 0; i < N_LS; i++) begin
      ls_idx[i] = $urandom_range(0, TOTAL_WORDS - 1);
      run_txn(1'b1, ls_idx[i], amo_mem_pkg::be_t'($urandom_range(0, 15)), $urandom, 4'h0,
              rand_hart(), rd);
    end
    for (int unsigned i = 0; i < N_LS; i++) begin
      run_txn(1'b0, ls_idx[i], 4'hf, 32'h0, 4'h0, rand_hart(), rd);
    end
    end_test("loads and stores");

    // All nine RMW operations in turn, operands biased to the extremes
    for (int unsigned i = 0; i < N_RMW; i++) begin
      w = $urandom_range(0, TOTAL_WORDS - 1);
      op = 4'(1 + (i % 9));
      case ($urandom_range(0, 7))
        0: opd = 32'h8000_0000;
        1: opd = 32'h7fff_ffff;
        2: opd = 32'hffff_ffff;
        3: opd = 32'h0000_0000;
        default: opd = $urandom;
      endcase
      run_txn(1'b0, w, 4'hf, opd, op, rand_hart(), rd);
      run_txn(1'b0, w, 4'hf, 32'h0, 4'h0, rand_hart(), rd);
    end
    end_test("rmw atomics");

    w = $urandom_range(0, TOTAL_WORDS - 1);
    run_txn(1'b0, w, 4'hf, 32'h0, amo_mem_pkg::LR, HART_A, rd);
    run_txn(1'b0, w, 4'hf, 32'hc0de_0001, amo_mem_pkg::SC, HART_A, rd);
    check_sc(rd, 1'b0);
    run_txn(1'b0, w, 4'hf, 32'h0, 4'h0, HART_A, rd);
    run_txn(1'b0, w, 4'hf, 32'hc0de_0002, amo_mem_pkg::SC, HART_A, rd);
    check_sc(rd, 1'b1);
    run_txn(1'b0, w, 4'hf, 32'h0, 4'h0, HART_A, rd);
    end_test("reservation success");

    // Word in bank 0, the others are its neighbours in the same and the next bank
    w = $urandom_range(0, WORDS_PER_BANK - 1) * NUM_BANKS;
    run_txn(1'b0, w, 4'hf, 32'h0, amo_mem_pkg::LR, HART_A, rd);
    run_txn(1'b1, w, 4'hf, 32'hb0b0_0001, 4'h0, HART_B, rd);
    run_txn(1'b0, w, 4'hf, 32'hc0de_0003, amo_mem_pkg::SC, HART_A, rd);
    check_sc(rd, 1'b1);
    run_txn(1'b0, w, 4'hf, 32'h0, 4'h0, HART_A, rd);
    run_txn(1'b0, w, 4'hf, 32'h0, amo_mem_pkg::LR, HART_A, rd);
    run_txn(1'b0, w, 4'hf, 32'h0000_0010, amo_mem_pkg::ADD, HART_B, rd);
    run_txn(1'b0, w, 4'hf, 32'hc0de_0004, amo_mem_pkg::SC, HART_A, rd);
    check_sc(rd, 1'b1);
    run_txn(1'b0, w, 4'hf, 32'h0, 4'h0, HART_A, rd);
    run_txn(1'b0, w, 4'hf, 32'h0, amo_mem_pkg::LR, HART_A, rd);
    run_txn(1'b1, (w + NUM_BANKS) % TOTAL_WORDS, 4'hf, 32'hb0b0_0002, 4'h0, HART_B, rd);
    run_txn(1'b1, w + 1, 4'hf, 32'hb0b0_0003, 4'h0, HART_B, rd);
    run_txn(1'b0, w, 4'hf, 32'hc0de_0005, amo_mem_pkg::SC, HART_A, rd);
    check_sc(rd, 1'b0);
    run_txn(1'b0, w, 4'hf, 32'h0, 4'h0, HART_A, rd);
    end_test("reservation loss");

    // Illegal opcodes carry a store that must not land
    w = $urandom_range(0, TOTAL_WORDS - 1);
    for (int unsigned k = 12; k < 16; k++) begin
      op = k[3:0];
      run_txn(1'b1, w, 4'hf, $urandom, op, rand_hart(), rd);
      run_txn(1'b0, w, 4'hf, 32'h0, 4'h0, rand_hart(), rd);
    end
    end_test("illegal opcodes");

    $display("tests %0d, transactions %0d, errors %0d", test_cnt, txn_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/*
  Testbench clock and reset source
  Reset is released on a falling edge after RESET_CYCLES rising edges
*/
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  // Free running clock, low in the first half period
  always begin
    clk_o = 1'b0;
    #(PERIOD_NS / 2);
    clk_o = 1'b1;
    #(PERIOD_NS / 2);
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: wb_bank_router.sv
/*
  Wishbone classic slave front end, one transaction in flight
  Bank from word address bits [log2(NUM_BANKS)+1:2], NUM_BANKS >= 2
  Address bits above the bank and word fields are ignored
*/
`timescale 1ns/100ps
`default_nettype none

module wb_bank_router #(
  parameter int unsigned  NUM_BANKS      = 4,
  parameter int unsigned  WORDS_PER_BANK = 64,
  parameter int unsigned  HART_ID_W      = 4,
  localparam int unsigned BANK_W         = amo_mem_pkg::idx_width(NUM_BANKS),
  localparam int unsigned WORD_W         = amo_mem_pkg::idx_width(WORDS_PER_BANK)
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 wb_cyc_i,
  input  wire logic                 wb_stb_i,
  input  wire logic                 wb_we_i,
  input  amo_mem_pkg::addr_t        wb_adr_i,
  input  amo_mem_pkg::be_t          wb_sel_i,
  input  amo_mem_pkg::data_t        wb_dat_i,
  input  wire logic [3:0]           amo_op_i,
  input  wire logic [HART_ID_W-1:0] hart_id_i,
  input  wire logic                 done_i,
  output logic [NUM_BANKS-1:0]      bank_req_o,
  output logic [WORD_W-1:0]         word_addr_o,
  output logic                      write_o,
  output amo_mem_pkg::data_t        wdata_o,
  output amo_mem_pkg::be_t          be_o,
  output amo_mem_pkg::amo_op_e      op_o,
  output logic [HART_ID_W-1:0]      hart_id_o
);

  logic busy_q;
  logic accept;
  logic [BANK_W-1:0] bank_idx;

  // Word interleaving, byte offset bits [1:0] dropped
  assign bank_idx    = wb_adr_i[2 +: BANK_W];
  assign word_addr_o = wb_adr_i[2 + BANK_W +: WORD_W];

  // Held stb is taken once, then blocked until the response
  assign accept = wb_cyc_i && wb_stb_i && !busy_q;

  always_comb begin
    bank_req_o           = '0;
    bank_req_o[bank_idx] = accept;
  end

  // Shared payload straight from the bus
  assign write_o   = wb_we_i;
  assign wdata_o   = wb_dat_i;
  assign be_o      = wb_sel_i;
  assign op_o      = amo_mem_pkg::amo_op_e'(amo_op_i);
  assign hart_id_o = hart_id_i;

  // Busy from accept until the edge after done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (done_i) begin
      busy_q <= 1'b0;
    end
  end

  a_no_req_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_q |-> bank_req_o == '0);
  // A bank answers only to a request this router issued
  a_done_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> busy_q);

endmodule

`default_nettype wire
